//--- hw/lsu_ctrl_pkg.sv
/*
  Request-side widths and LSU operation codes for an RV32 core.
  Bit LSU_CTRL_WIDTH-1 of every code marks a store, loads keep it clear.
  Codes are not one-hot, so decoders compare the whole field.
*/

package lsu_ctrl_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int DATA_WIDTH     = 32;  // Data and address width, fixed by RV32
  localparam int REG_ADDR_WIDTH = 5;   // x0..x31
  localparam int LSU_CTRL_WIDTH = 4;   // MSB set means store

  ////////////////////
  // Load codes
  ////////////////////
  localparam logic [LSU_CTRL_WIDTH-1:0] LSU_LOAD_BYTE        = 4'b0000;  // LB
  localparam logic [LSU_CTRL_WIDTH-1:0] LSU_LOAD_BYTE_U      = 4'b0001;  // LBU
  localparam logic [LSU_CTRL_WIDTH-1:0] LSU_LOAD_HALF_WORD   = 4'b0010;  // LH
  localparam logic [LSU_CTRL_WIDTH-1:0] LSU_LOAD_HALF_WORD_U = 4'b0011;  // LHU
  localparam logic [LSU_CTRL_WIDTH-1:0] LSU_LOAD_WORD        = 4'b0100;  // LW

  ////////////////////
  // Store codes
  ////////////////////
  // Store codes share the low bits with the matching load size
  localparam logic [LSU_CTRL_WIDTH-1:0] LSU_STORE_BYTE       = 4'b1000;  // SB
  localparam logic [LSU_CTRL_WIDTH-1:0] LSU_STORE_HALF_WORD  = 4'b1010;  // SH
  localparam logic [LSU_CTRL_WIDTH-1:0] LSU_STORE_WORD       = 4'b1100;  // SW

endpackage : lsu_ctrl_pkg

//--- hw/lsu_bus_pkg.sv
/*
  Data RAM bus geometry: a 32-bit word split into four byte lanes.
  Lane 0 is the least significant byte (little endian).
*/

package lsu_bus_pkg;

  ////////////////////
  // Lane geometry
  ////////////////////
  localparam int BYTE_LANES = 4;                        // One enable per lane
  localparam int BYTE_WIDTH = 8;
  localparam int HALF_LANES = BYTE_LANES / 2;           // Two halfwords per word
  localparam int HALF_WIDTH = 2 * BYTE_WIDTH;
  localparam int BUS_WIDTH  = BYTE_LANES * BYTE_WIDTH;  // 32-bit data bus

  ////////////////////
  // Word views
  ////////////////////
  // Same 32 bits, indexed either by byte lane or by halfword
  typedef union packed {
    logic [BYTE_LANES-1:0][BYTE_WIDTH-1:0] bytes;   // bytes[0] = bits 7:0
    logic [HALF_LANES-1:0][HALF_WIDTH-1:0] halves;  // halves[1] = bits 31:16
  } lsu_word_u;

endpackage : lsu_bus_pkg

//--- hw/lsu_addr_check.sv
/*
  Natural alignment check for each valid request.
  misaligned_store_o is combinational in the request cycle.
  Registered flags pulse once, T+1. Address and load flag held until next request.
*/

module lsu_addr_check (
  input  logic                                    clk_i,
  input  logic                                    rstn_i,
  input  logic                                    ctrl_valid_i,
  input  logic [lsu_ctrl_pkg::LSU_CTRL_WIDTH-1:0] ctrl_i,
  input  logic [lsu_ctrl_pkg::DATA_WIDTH-1:0]     addr_i,
  output logic                                    misaligned_store_o,     // To issuer, same cycle
  output logic                                    misaligned_load_o,      // CSR pulse
  output logic                                    misaligned_store_ro,    // CSR pulse
  output logic                                    misaligned_load_hold_o, // To load extractor
  output logic [lsu_ctrl_pkg::DATA_WIDTH-1:0]     exception_addr_o
);
  import lsu_ctrl_pkg::*;

  logic misaligned_load;  // Combinational load fault

  // Halfwords need bit 0 clear, words need bits 1:0 clear
  always_comb begin
    misaligned_load    = 1'b0;
    misaligned_store_o = 1'b0;
    if (ctrl_valid_i) begin
      case (ctrl_i)
        LSU_LOAD_HALF_WORD,
        LSU_LOAD_HALF_WORD_U: misaligned_load    = addr_i[0];
        LSU_LOAD_WORD:        misaligned_load    = |addr_i[1:0];
        LSU_STORE_HALF_WORD:  misaligned_store_o = addr_i[0];
        LSU_STORE_WORD:       misaligned_store_o = |addr_i[1:0];
        default:              ;  // Byte access is always aligned
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      misaligned_load_o      <= 1'b0;
      misaligned_store_ro    <= 1'b0;
      misaligned_load_hold_o <= 1'b0;
    end else begin
      misaligned_load_o   <= misaligned_load;     // One cycle only
      misaligned_store_ro <= misaligned_store_o;
      if (ctrl_valid_i) misaligned_load_hold_o <= misaligned_load;  // Kept for the ack
    end
  end

  // Faulting address for mtval, last valid request wins
  always_ff @(posedge clk_i) begin
    if (ctrl_valid_i) exception_addr_o <= addr_i;
  end

endmodule : lsu_addr_check

//--- hw/lsu_store_align.sv
/*
  Purely combinational store lane placement.
  Lane is chosen by addr_low_i only, alignment is not checked here.
  Loads and idle cycles give zero data and zero byte enables.
*/

module lsu_store_align (
  input  logic [lsu_ctrl_pkg::LSU_CTRL_WIDTH-1:0] ctrl_i,
  input  logic [1:0]                              addr_low_i,  // Byte offset in word
  input  logic [lsu_ctrl_pkg::DATA_WIDTH-1:0]     wdata_i,     // rs2 value
  output lsu_bus_pkg::lsu_word_u                  wword_o,     // Lane-placed data
  output logic [lsu_bus_pkg::BYTE_LANES-1:0]      we_o         // Byte enables
);
  import lsu_ctrl_pkg::*;
  import lsu_bus_pkg::*;

  logic is_store;  // MSB of the op code

  assign is_store = ctrl_i[LSU_CTRL_WIDTH-1];

  ////////////////////
  // Lane placement
  ////////////////////
  always_comb begin
    wword_o = '0;  // Unused lanes stay zero
    we_o    = '0;
    if (is_store) begin
      case (ctrl_i)
        LSU_STORE_BYTE: begin
          wword_o.bytes[addr_low_i] = wdata_i[BYTE_WIDTH-1:0];  // Low byte of rs2
          we_o[addr_low_i]          = 1'b1;
        end
        LSU_STORE_HALF_WORD: begin
          // Bit 0 of the offset is ignored, the checker flags it
          wword_o.halves[addr_low_i[1]] = wdata_i[HALF_WIDTH-1:0];
          we_o[{addr_low_i[1], 1'b0} +: 2] = 2'b11;
        end
        LSU_STORE_WORD: begin
          wword_o.bytes = wdata_i;  // Full word, no shift
          we_o          = '1;
        end
        default: begin
          // Undefined store code, nothing written
          wword_o = '0;
          we_o    = '0;
        end
      endcase
    end
  end

endmodule : lsu_store_align

//--- hw/lsu_mem_issue.sv
/*
  Registered RAM bus request, presented one cycle after the core request.
  No back-pressure: the RAM must ack before the next strobe is needed.
  Byte enables are zero for loads, idle cycles and misaligned stores.
*/

module lsu_mem_issue (
  input  logic                                   clk_i,
  input  logic                                   rstn_i,
  input  logic                                   ctrl_valid_i,
  input  logic [lsu_ctrl_pkg::DATA_WIDTH-1:0]    addr_i,
  input  lsu_bus_pkg::lsu_word_u                 wword_i,            // From store aligner
  input  logic [lsu_bus_pkg::BYTE_LANES-1:0]     we_i,               // From store aligner
  input  logic                                   misaligned_store_i, // From address checker
  output logic                                   mem_stb_o,
  output logic [lsu_ctrl_pkg::DATA_WIDTH-1:0]    mem_addr_o,
  output logic [lsu_bus_pkg::BYTE_LANES-1:0]     mem_we_o,
  output logic [lsu_bus_pkg::BUS_WIDTH-1:0]      mem_wdata_o
);
  import lsu_bus_pkg::*;

  logic write_ok;  // Request may touch memory

  assign write_ok = ctrl_valid_i & ~misaligned_store_i;

  ////////////////////
  // Bus control
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mem_stb_o <= 1'b0;
      mem_we_o  <= '0;
    end else begin
      mem_stb_o <= ctrl_valid_i;                    // One strobe per request
      mem_we_o  <= we_i & {BYTE_LANES{write_ok}};  // Faulting store never writes
    end
  end

  // Address and data only matter while mem_stb_o is high
  always_ff @(posedge clk_i) begin
    mem_addr_o  <= addr_i;
    mem_wdata_o <= wword_i;
  end

endmodule : lsu_mem_issue

//--- hw/lsu_load_extract.sv
/*
  Load return path: capture on ack, lane select, sign or zero extension.
  Request info is staged once per strobe, so at most one ack may be pending
  per strobe cycle. rdata_o and rf_wb_o are valid the cycle after the ack.
*/

module lsu_load_extract (
  input  logic                                    clk_i,
  input  logic                                    rstn_i,
  input  logic                                    ctrl_valid_i,
  input  logic [lsu_ctrl_pkg::LSU_CTRL_WIDTH-1:0] ctrl_i,
  input  logic [1:0]                              addr_low_i,
  input  logic [lsu_ctrl_pkg::REG_ADDR_WIDTH-1:0] regdest_i,
  input  logic                                    misaligned_load_hold_i,
  input  logic                                    mem_ack_i,
  input  logic [lsu_bus_pkg::BUS_WIDTH-1:0]       mem_rdata_i,
  input  logic                                    mem_err_i,
  output logic [lsu_ctrl_pkg::DATA_WIDTH-1:0]     rdata_o,    // To register file
  output logic                                    rf_wb_o,    // Register file write enable
  output logic [lsu_ctrl_pkg::REG_ADDR_WIDTH-1:0] regdest_o,
  output logic                                    bus_error_o
);
  import lsu_ctrl_pkg::*;
  import lsu_bus_pkg::*;

  logic [LSU_CTRL_WIDTH-1:0] ctrl_req_q, ctrl_bus_q, ctrl_ret_q;  // Op per stage
  logic [1:0]                off_req_q, off_bus_q, off_ret_q;     // Byte offset per stage
  logic                      issued_q;     // Copy of the bus strobe
  logic                      mis_bus_q;    // Misaligned load of the request on the bus
  lsu_word_u                 data_q;       // RAM word from the ack cycle
  logic [BYTE_WIDTH-1:0]     sel_byte;
  logic [HALF_WIDTH-1:0]     sel_half;

  ////////////////////
  // Request staging
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      issued_q   <= 1'b0;
      mis_bus_q  <= 1'b0;
      ctrl_req_q <= '0;
      ctrl_bus_q <= '0;
      ctrl_ret_q <= '0;
      rf_wb_o    <= 1'b0;
      regdest_o  <= '0;
    end else begin
      issued_q  <= ctrl_valid_i;
      regdest_o <= regdest_i;                  // One cycle delay
      if (ctrl_valid_i) ctrl_req_q <= ctrl_i;  // Request cycle
      if (issued_q) begin                      // Strobe cycle, frees the request stage
        ctrl_bus_q <= ctrl_req_q;
        mis_bus_q  <= misaligned_load_hold_i;
      end
      if (mem_ack_i) ctrl_ret_q <= ctrl_bus_q;
      rf_wb_o <= mem_ack_i & ~mis_bus_q;       // Stores pulse too, with regdest 0
    end
  end

  // Offsets and returned data follow the control stages
  always_ff @(posedge clk_i) begin
    if (ctrl_valid_i) off_req_q <= addr_low_i;
    if (issued_q)     off_bus_q <= off_req_q;
    if (mem_ack_i) begin
      off_ret_q <= off_bus_q;
      data_q    <= mem_rdata_i;
    end
  end

  ////////////////////
  // Lane select and extension
  ////////////////////
  assign sel_byte = data_q.bytes[off_ret_q];
  assign sel_half = data_q.halves[off_ret_q[1]];

  always_comb begin
    case (ctrl_ret_q)
      LSU_LOAD_BYTE:        rdata_o = {{(DATA_WIDTH-BYTE_WIDTH){sel_byte[BYTE_WIDTH-1]}}, sel_byte};
      LSU_LOAD_BYTE_U:      rdata_o = {{(DATA_WIDTH-BYTE_WIDTH){1'b0}}, sel_byte};
      LSU_LOAD_HALF_WORD:   rdata_o = {{(DATA_WIDTH-HALF_WIDTH){sel_half[HALF_WIDTH-1]}}, sel_half};
      LSU_LOAD_HALF_WORD_U: rdata_o = {{(DATA_WIDTH-HALF_WIDTH){1'b0}}, sel_half};
      LSU_LOAD_WORD:        rdata_o = data_q;
      default:              rdata_o = '0;  // Stores return nothing
    endcase
  end

  // Error pulse may come in any cycle
  always_ff @(posedge clk_i) begin
    if (!rstn_i) bus_error_o <= 1'b0;
    else         bus_error_o <= mem_err_i;
  end

endmodule : lsu_load_extract

//--- hw/lsu_top.sv
/*
  Load-store unit top: address check and store align in parallel,
  registered RAM request, load extraction on the return path.
  Plain stb/ack/err bus, one outstanding request per ack.
*/

module lsu_top (
  input  logic                                    clk_i,
  input  logic                                    rstn_i,
  // Core request side
  input  logic                                    ctrl_valid_i,
  input  logic [lsu_ctrl_pkg::LSU_CTRL_WIDTH-1:0] ctrl_i,
  input  logic [lsu_ctrl_pkg::DATA_WIDTH-1:0]     addr_i,
  input  logic [lsu_ctrl_pkg::DATA_WIDTH-1:0]     wdata_i,
  input  logic [lsu_ctrl_pkg::REG_ADDR_WIDTH-1:0] regdest_i,
  // Register file and CSR side
  output logic [lsu_ctrl_pkg::DATA_WIDTH-1:0]     rdata_o,
  output logic                                    rf_wb_o,
  output logic [lsu_ctrl_pkg::REG_ADDR_WIDTH-1:0] regdest_o,
  output logic                                    misaligned_load_o,
  output logic                                    misaligned_store_o,
  output logic                                    bus_error_o,
  output logic [lsu_ctrl_pkg::DATA_WIDTH-1:0]     exception_addr_o,
  // Data RAM side
  output logic                                    mem_stb_o,
  output logic [lsu_ctrl_pkg::DATA_WIDTH-1:0]     mem_addr_o,
  output logic [lsu_bus_pkg::BYTE_LANES-1:0]      mem_we_o,
  output logic [lsu_bus_pkg::BUS_WIDTH-1:0]       mem_wdata_o,
  input  logic                                    mem_ack_i,
  input  logic [lsu_bus_pkg::BUS_WIDTH-1:0]       mem_rdata_i,
  input  logic                                    mem_err_i
);
  import lsu_bus_pkg::*;

  logic                  mis_store_lvl;  // Same-cycle store fault
  logic                  mis_load_hold;  // Held load fault
  lsu_word_u             lane_word;      // Aligned store data
  logic [BYTE_LANES-1:0] lane_we;        // Unmasked byte enables

  lsu_addr_check u_addr_check (
    .clk_i, .rstn_i, .ctrl_valid_i, .ctrl_i, .addr_i,
    .misaligned_store_o     (mis_store_lvl),
    .misaligned_load_o      (misaligned_load_o),
    .misaligned_store_ro    (misaligned_store_o),
    .misaligned_load_hold_o (mis_load_hold),
    .exception_addr_o       (exception_addr_o)
  );

  lsu_store_align u_store_align (
    .ctrl_i, .wdata_i, .addr_low_i (addr_i[1:0]), .wword_o (lane_word), .we_o (lane_we)
  );

  lsu_mem_issue u_mem_issue (
    .clk_i, .rstn_i, .ctrl_valid_i, .addr_i, .wword_i (lane_word), .we_i (lane_we),
    .misaligned_store_i (mis_store_lvl),
    .mem_stb_o, .mem_addr_o, .mem_we_o, .mem_wdata_o
  );

  lsu_load_extract u_load_extract (
    .clk_i, .rstn_i, .ctrl_valid_i, .ctrl_i, .addr_low_i (addr_i[1:0]), .regdest_i,
    .misaligned_load_hold_i (mis_load_hold),
    .mem_ack_i, .mem_rdata_i, .mem_err_i, .rdata_o, .rf_wb_o, .regdest_o, .bus_error_o
  );

endmodule : lsu_top

//--- tb/tb_data_ram.sv
/*
  Behavioural data RAM for the LSU testbench, 256 words (0x000..0x3FF).
  Acks one cycle after each strobe. Strobes at or above 0x400 get ack plus err.
  Preloaded with a pattern built from the word index.
*/

module tb_data_ram (
  input  logic        clk_i,
  input  logic        rstn_i,
  input  logic        stb_i,
  input  logic [31:0] addr_i,
  input  logic [3:0]  we_i,     // Byte enables
  input  logic [31:0] wdata_i,
  output logic        ack_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] mem [0:255];
  logic        in_range;  // Inside the 1 KiB window
  logic [7:0]  idx;

  assign in_range = (addr_i < 32'h400);
  assign idx      = addr_i[9:2];

  initial begin
    for (int w = 0; w < 256; w++) begin
      mem[w] = {~w[7:0], w[7:0] ^ 8'hA5, w[7:0], 8'h3C ^ {w[3:0], w[7:4]}};  // Fill
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= stb_i;                 // One ack per strobe
      err_o <= stb_i & ~in_range;     // Error window
      if (stb_i && in_range) begin
        rdata_o <= mem[idx];          // Read before write
        for (int k = 0; k < 4; k++) begin
          if (we_i[k]) mem[idx][8*k +: 8] <= wdata_i[8*k +: 8];
        end
      end else if (stb_i) begin
        rdata_o <= '0;
      end
    end
  end

endmodule : tb_data_ram

//--- tb/tb_lsu.sv
/*
  LSU testbench with random stores and loads against a byte shadow memory.
  Concurrent assertions check timing, flags and load data.
  Inputs change 1 ns after the rising edge.
*/

module tb_lsu;
  timeunit 1ns;
  timeprecision 1ps;
  import lsu_ctrl_pkg::*;

  localparam int N_STORE   = 12;
  localparam int N_LOAD    = 20;
  localparam int N_B2B     = 8;
  localparam int N_REQ     = N_STORE + N_LOAD + N_B2B + 7;  // 7 fault requests
  localparam int CLK_NS    = 8;
  localparam int LIMIT_NS  = (N_REQ * 4 + 50) * CLK_NS;

  logic        clk_i, rstn_i, ctrl_valid_i;
  logic [3:0]  ctrl_i;
  logic [31:0] addr_i, wdata_i, rdata_o, exception_addr_o;
  logic [4:0]  regdest_i, regdest_o;
  logic        rf_wb_o, misaligned_load_o, misaligned_store_o, bus_error_o;
  logic        mem_stb_o, mem_ack_i, mem_err_i;
  logic [31:0] mem_addr_o, mem_wdata_o, mem_rdata_i;
  logic [3:0]  mem_we_o;

  logic [7:0]  shadow [0:1023];   // Expected memory contents
  logic [31:0] exp_data [0:63];   // Expected writeback data, in order
  logic        exp_chk [0:63];    // Entry holds a load result to compare
  logic [4:0]  exp_rd [0:63];     // Expected writeback register
  logic        exp_rdv [0:63];    // Entry has a writeback register to compare
  logic        rd_stable;         // Requests spaced so regdest_i holds until writeback
  logic [31:0] req_addr;          // Address of the last valid request
  int          wr_ptr, rd_ptr;
  logic [31:0] rng_state;
  string       test_name;

  lsu_top dut0 (.*);

  tb_data_ram u_ram (
    .clk_i, .rstn_i, .stb_i (mem_stb_o), .addr_i (mem_addr_o), .we_i (mem_we_o),
    .wdata_i (mem_wdata_o), .ack_o (mem_ack_i), .rdata_o (mem_rdata_i), .err_o (mem_err_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  // Run limit
  initial begin
    #(LIMIT_NS);
    $display("timeout: the LSU did not finish the request sequence in time");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////
  // Helpers
  ////////////////////
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic is_mis_load(logic [3:0] op, logic [31:0] a);
    if (op == LSU_LOAD_HALF_WORD || op == LSU_LOAD_HALF_WORD_U) return a[0];
    if (op == LSU_LOAD_WORD) return |a[1:0];
    return 1'b0;
  endfunction

  function automatic logic is_mis_store(logic [3:0] op, logic [31:0] a);
    if (op == LSU_STORE_HALF_WORD) return a[0];
    if (op == LSU_STORE_WORD) return |a[1:0];
    return 1'b0;
  endfunction

  // Extension rules of LB/LBU/LH/LHU/LW on the shadow bytes
  function automatic logic [31:0] predict_load(logic [3:0] op, logic [31:0] a);
    logic [7:0]  b;
    logic [15:0] h;
    b = shadow[a];
    h = {shadow[a + 1], shadow[a]};
    case (op)
      LSU_LOAD_BYTE:        return {{24{b[7]}}, b};
      LSU_LOAD_BYTE_U:      return {24'h0, b};
      LSU_LOAD_HALF_WORD:   return {{16{h[15]}}, h};
      LSU_LOAD_HALF_WORD_U: return {16'h0, h};
      default:              return {shadow[a + 3], shadow[a + 2], h};
    endcase
  endfunction

  task automatic report_error(string name, logic [31:0] exp_v, logic [31:0] act_v);
    $display("error %s expected %h actual %h", name, exp_v, act_v);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic push_expect(logic chk, logic [31:0] d, logic [4:0] rd);
    exp_data[wr_ptr] = d;
    exp_chk[wr_ptr]  = chk;
    exp_rd[wr_ptr]   = rd;
    exp_rdv[wr_ptr]  = rd_stable;
    wr_ptr++;
  endtask

  // Drives one request for one cycle, updates the model
  task automatic issue(logic [3:0] op, logic [31:0] a, logic [31:0] wd, logic [4:0] rd);
    @(posedge clk_i);
    #1;
    ctrl_valid_i = 1'b1;
    ctrl_i       = op;
    addr_i       = a;
    wdata_i      = wd;
    regdest_i    = rd;
    if (op[3]) begin
      push_expect(1'b0, '0, 5'd0);                     // Store ack writes back to x0
      if (!is_mis_store(op, a) && a < 32'h400) begin
        shadow[a] = wd[7:0];
        if (op != LSU_STORE_BYTE) shadow[a + 1] = wd[15:8];
        if (op == LSU_STORE_WORD) begin
          shadow[a + 2] = wd[23:16];
          shadow[a + 3] = wd[31:24];
        end
      end
    end else if (!is_mis_load(op, a)) begin
      push_expect(a < 32'h400, (a < 32'h400) ? predict_load(op, a) : '0, rd);
    end
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      ctrl_valid_i = 1'b0;
    end
  endtask

  ////////////////////
  // Checks
  ////////////////////
  assert property (@(posedge clk_i) $rose(rstn_i) |->
      !rf_wb_o && !mem_stb_o && mem_we_o == 0 && !misaligned_load_o &&
      !misaligned_store_o && !bus_error_o)
    else report_error("reset_state", 0, {rf_wb_o, mem_stb_o, misaligned_load_o, bus_error_o});

  assert property (@(posedge clk_i) disable iff (!rstn_i)
      rf_wb_o && exp_chk[rd_ptr] |-> rdata_o == exp_data[rd_ptr])
    else report_error(test_name, $sampled(exp_data[rd_ptr]), $sampled(rdata_o));

  assert property (@(posedge clk_i) disable iff (!rstn_i)
      rf_wb_o && exp_rdv[rd_ptr] |-> regdest_o == exp_rd[rd_ptr])
    else report_error({test_name, "_regdest"}, $sampled(exp_rd[rd_ptr]), $sampled(regdest_o));

  assert property (@(posedge clk_i) disable iff (!rstn_i)
      ctrl_valid_i && !is_mis_load(ctrl_i, addr_i) |-> ##3 rf_wb_o)
    else report_error({test_name, "_wb_timing"}, 1, 0);

  assert property (@(posedge clk_i) disable iff (!rstn_i)
      ctrl_valid_i && is_mis_load(ctrl_i, addr_i) |=> misaligned_load_o ##2 !rf_wb_o)
    else report_error({test_name, "_mis_load"}, 1, 0);

  assert property (@(posedge clk_i) disable iff (!rstn_i)
      ctrl_valid_i && is_mis_store(ctrl_i, addr_i) |=> misaligned_store_o && mem_we_o == 0)
    else report_error({test_name, "_mis_store"}, 1, $sampled(misaligned_store_o));

  assert property (@(posedge clk_i) disable iff (!rstn_i)
      ctrl_valid_i |=> exception_addr_o == $past(addr_i) && regdest_o == $past(regdest_i))
    else report_error({test_name, "_addr_rd"}, $sampled(req_addr), $sampled(exception_addr_o));

  assert property (@(posedge clk_i) disable iff (!rstn_i)
      ctrl_valid_i |=> mem_stb_o && mem_addr_o == req_addr)
    else report_error({test_name, "_bus_req"}, $sampled(req_addr), $sampled(mem_addr_o));

  assert property (@(posedge clk_i) disable iff (!rstn_i)
      ctrl_valid_i && addr_i >= 32'h400 |-> ##3 bus_error_o)
    else report_error({test_name, "_bus_err"}, 1, 0);

  assert property (@(posedge clk_i) disable iff (!rstn_i) mem_err_i |=> bus_error_o)
    else report_error({test_name, "_err_delay"}, 1, 0);

  always @(posedge clk_i) begin
    if (rf_wb_o) rd_ptr <= rd_ptr + 1;  // Writebacks come back in order
  end

  always @(posedge clk_i) begin
    if (ctrl_valid_i) req_addr <= addr_i;
  end

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    logic [31:0] a;
    logic [3:0]  op;
    logic [31:0] fill;
    rng_state = 32'd9949;
    wr_ptr = 0;
    rd_ptr = 0;
    rd_stable = 1'b1;
    test_name = "reset";
    rstn_i = 1'b0;
    ctrl_valid_i = 1'b0;
    ctrl_i = '0;
    addr_i = '0;
    wdata_i = '0;
    regdest_i = '0;
    for (int w = 0; w < 256; w++) begin
      fill = {~w[7:0], w[7:0] ^ 8'hA5, w[7:0], 8'h3C ^ {w[3:0], w[7:4]}};
      for (int k = 0; k < 4; k++) begin
        shadow[4*w + k] = fill[8*k +: 8];
      end
    end
    repeat (2) @(posedge clk_i);
    #1;
    rstn_i = 1'b1;

    test_name = "aligned_rw";
    for (int i = 0; i < N_STORE; i++) begin
      op = (i % 3 == 0) ? LSU_STORE_BYTE : (i % 3 == 1) ? LSU_STORE_HALF_WORD : LSU_STORE_WORD;
      a  = next_rand() & 32'h3F;
      a  = (op == LSU_STORE_BYTE) ? a : (op == LSU_STORE_HALF_WORD) ? a & ~32'h1 : a & ~32'h3;
      issue(op, a, next_rand(), 5'd0);
      idle(3);
    end
    for (int i = 0; i < N_LOAD; i++) begin
      op = 4'(i % 5);                            // Codes 0..4 are the loads
      a  = next_rand() & 32'h3F;
      a  = (op < 2) ? a : (op < 4) ? a & ~32'h1 : a & ~32'h3;
      issue(op, a, '0, 5'd1 + 5'(i % 31));
      idle(3);
    end
    idle(1);

    test_name = "mis_store";
    issue(LSU_STORE_HALF_WORD, 32'h41, next_rand(), 5'd0);
    idle(3);
    issue(LSU_STORE_WORD, 32'h42, next_rand(), 5'd0);
    idle(3);
    issue(LSU_LOAD_WORD, 32'h40, '0, 5'd7);    // Memory must be unchanged
    idle(4);

    test_name = "mis_load";
    issue(LSU_LOAD_HALF_WORD, 32'h23, '0, 5'd3);
    idle(3);
    issue(LSU_LOAD_WORD, 32'h21, '0, 5'd4);
    idle(4);

    test_name = "bus_error";
    issue(LSU_LOAD_WORD, 32'h400, '0, 5'd5);
    idle(3);
    issue(LSU_STORE_WORD, 32'h500, next_rand(), 5'd0);
    idle(4);

    test_name = "back_to_back";
    rd_stable = 1'b0;                            // regdest_i moves on before the writeback
    for (int i = 0; i < N_B2B; i++) begin
      issue(LSU_LOAD_WORD, (next_rand() & 32'h3FC), '0, 5'd10 + 5'(i));
    end
    idle(6);

    if (rd_ptr == wr_ptr) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("writeback count %0d does not match request count %0d", rd_ptr, wr_ptr);
      $display("TEST FAILED");
      $fatal(1, "writeback count mismatch");
    end
  end

endmodule : tb_lsu

//--- compile.f
hw/lsu_ctrl_pkg.sv
hw/lsu_bus_pkg.sv
hw/lsu_addr_check.sv
hw/lsu_store_align.sv
hw/lsu_mem_issue.sv
hw/lsu_load_extract.sv
hw/lsu_top.sv
tb/tb_data_ram.sv
tb/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - hw/lsu_ctrl_pkg.sv
  - hw/lsu_bus_pkg.sv
  - hw/lsu_addr_check.sv
  - hw/lsu_store_align.sv
  - hw/lsu_mem_issue.sv
  - hw/lsu_load_extract.sv
  - hw/lsu_top.sv
  - target: test
    files:
      - tb/tb_data_ram.sv
      - tb/tb_lsu.sv
